/* logic/rv_core_pkg.sv */
// core widths, typedefs, opcode and ALU codes, pipeline stage structs
package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [1:0]      branch_t;
    typedef logic [1:0]      fwd_sel_t;

    // --------------------
    // instruction encodings
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_PASS_B = 4'd6;

    localparam branch_t BR_NONE = 2'd0;
    localparam branch_t BR_EQ   = 2'd1;
    localparam branch_t BR_NE   = 2'd2;
    localparam branch_t BR_LT   = 2'd3;

    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;

    // --------------------
    // stage payloads
    typedef struct packed {
        alu_op_t alu_op;
        branch_t branch;
        logic    jump;
        logic    use_imm;
        logic    use_pc_src1;
        logic    mem_rd;
        logic    mem_wr;
        logic    reg_wr;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
    } dec_t;

    typedef struct packed {
        logic      mem_rd;
        logic      mem_wr;
        logic      reg_wr;
        logic      link;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     store_data;
        word_t     link_addr;
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

/* logic/fetch_stage.sv */
// program counter and fetch/decode pipeline register
`timescale 1ns/100ps

module fetch_stage
    import rv_core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  stall_i,
    input  logic  flush_i,
    input  logic  redirect_i,
    input  word_t target_i,
    input  word_t inst_i,
    output word_t pc_o,
    output word_t id_pc_o,
    output word_t id_inst_o
);

    word_t pc_q;
    word_t id_pc_q;
    word_t id_inst_q;

    // redirect wins over a load-use hold
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            id_inst_q <= NOP_INST;
        end else if (!stall_i) begin
            id_inst_q <= inst_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            id_pc_q <= pc_q;
        end
    end

    assign pc_o      = pc_q;
    assign id_pc_o   = id_pc_q;
    assign id_inst_o = id_inst_q;

endmodule

/* logic/decoder.sv */
// instruction decode into control fields and immediate generation
`timescale 1ns/100ps

module decoder
    import rv_core_pkg::*;
(
    input  word_t inst_i,
    output dec_t  dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       op_ok;
    alu_op_t    op_alu;
    branch_t    br_cond;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // --------------------
    // immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // register-register ops
    always_comb begin
        op_ok  = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
        op_alu = ALU_ADD;
        case (funct3)
            3'b000:  op_alu = funct7[5] ? ALU_SUB : ALU_ADD;
            3'b010:  op_alu = ALU_SLT;
            3'b100:  op_alu = ALU_XOR;
            3'b110:  op_alu = ALU_OR;
            3'b111:  op_alu = ALU_AND;
            default: op_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_cond = BR_EQ;
            3'b001:  br_cond = BR_NE;
            3'b100:  br_cond = BR_LT;
            default: br_cond = BR_NONE;
        endcase
    end

    // unused source fields stay at x0 so hazard checks ignore them
    always_comb begin
        dec_o = '0;
        case (opcode)
            OPC_LUI: begin
                dec_o.ctrl.alu_op  = ALU_PASS_B;
                dec_o.ctrl.use_imm = 1'b1;
                dec_o.ctrl.reg_wr  = 1'b1;
                dec_o.rd           = inst_i[11:7];
                dec_o.imm          = imm_u;
            end
            OPC_OPIMM, OPC_LOAD: begin
                if (funct3 == (opcode == OPC_LOAD ? 3'b010 : 3'b000)) begin
                    dec_o.ctrl.use_imm = 1'b1;
                    dec_o.ctrl.mem_rd  = (opcode == OPC_LOAD);
                    dec_o.ctrl.reg_wr  = 1'b1;
                    dec_o.rs1          = inst_i[19:15];
                    dec_o.rd           = inst_i[11:7];
                    dec_o.imm          = imm_i;
                end
            end
            OPC_OP: begin
                if (op_ok) begin
                    dec_o.ctrl.alu_op = op_alu;
                    dec_o.ctrl.reg_wr = 1'b1;
                    dec_o.rs1         = inst_i[19:15];
                    dec_o.rs2         = inst_i[24:20];
                    dec_o.rd          = inst_i[11:7];
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_o.ctrl.use_imm = 1'b1;
                    dec_o.ctrl.mem_wr  = 1'b1;
                    dec_o.rs1          = inst_i[19:15];
                    dec_o.rs2          = inst_i[24:20];
                    dec_o.imm          = imm_s;
                end
            end
            OPC_BRANCH: begin
                if (br_cond != BR_NONE) begin
                    dec_o.ctrl.alu_op = ALU_SUB;
                    dec_o.ctrl.branch = br_cond;
                    dec_o.rs1         = inst_i[19:15];
                    dec_o.rs2         = inst_i[24:20];
                    dec_o.imm         = imm_b;
                end
            end
            OPC_JAL: begin
                dec_o.ctrl.jump        = 1'b1;
                dec_o.ctrl.use_imm     = 1'b1;
                dec_o.ctrl.use_pc_src1 = 1'b1;
                dec_o.ctrl.reg_wr      = 1'b1;
                dec_o.rd               = inst_i[11:7];
                dec_o.imm              = imm_j;
            end
            default: dec_o = '0;
        endcase
    end

endmodule

/* logic/reg_file.sv */
// integer register file, two read ports and one write port
`timescale 1ns/100ps

module reg_file
    import rv_core_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  wb_t       wb_i
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* logic/execute_stage.sv */
// decode/execute register, operand forwarding, ALU and branch resolution
`timescale 1ns/100ps

module execute_stage
    import rv_core_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     flush_i,
    input  dec_t     dec_i,
    input  word_t    pc_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  fwd_sel_t fwd_a_i,
    input  fwd_sel_t fwd_b_i,
    input  wb_t      mem_fwd_i,
    input  wb_t      wb_fwd_i,
    output dec_t     id_ex_ctrl_o,
    output logic     redirect_o,
    output word_t    target_o,
    output ex_mem_t  ex_mem_o
);

    dec_t  ex_q;
    word_t pc_q;
    word_t rs1_q;
    word_t rs2_q;
    word_t op_a;
    word_t op_b;
    word_t src1;
    word_t src2;
    word_t alu_res;
    logic  taken;

    // register file write that lands on the same edge as this capture
    function automatic word_t wb_bypass(reg_addr_t idx, word_t rd_data, wb_t wb);
        if (wb.we && wb.rd != '0 && wb.rd == idx) begin
            return wb.data;
        end
        return rd_data;
    endfunction

    function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, wb_t mem_fwd, wb_t wb);
        case (sel)
            FWD_MEM: return mem_fwd.data;
            FWD_WB:  return wb.data;
            default: return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            ex_q <= '0;
        end else begin
            ex_q <= dec_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q  <= pc_i;
        rs1_q <= wb_bypass(dec_i.rs1, rs1_data_i, wb_fwd_i);
        rs2_q <= wb_bypass(dec_i.rs2, rs2_data_i, wb_fwd_i);
    end

    // --------------------
    // operands and ALU
    assign op_a = fwd_pick(fwd_a_i, rs1_q, mem_fwd_i, wb_fwd_i);
    assign op_b = fwd_pick(fwd_b_i, rs2_q, mem_fwd_i, wb_fwd_i);
    assign src1 = ex_q.ctrl.use_pc_src1 ? pc_q : op_a;
    assign src2 = ex_q.ctrl.use_imm ? ex_q.imm : op_b;

    always_comb begin
        case (ex_q.ctrl.alu_op)
            ALU_ADD:    alu_res = src1 + src2;
            ALU_SUB:    alu_res = src1 - src2;
            ALU_AND:    alu_res = src1 & src2;
            ALU_OR:     alu_res = src1 | src2;
            ALU_XOR:    alu_res = src1 ^ src2;
            ALU_SLT:    alu_res = word_t'($signed(src1) < $signed(src2));
            ALU_PASS_B: alu_res = src2;
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex_q.ctrl.branch)
            BR_EQ:   taken = (op_a == op_b);
            BR_NE:   taken = (op_a != op_b);
            BR_LT:   taken = ($signed(op_a) < $signed(op_b));
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o   = taken | ex_q.ctrl.jump;
    assign target_o     = pc_q + ex_q.imm;
    assign id_ex_ctrl_o = ex_q;

    assign ex_mem_o = '{
        mem_rd:     ex_q.ctrl.mem_rd,
        mem_wr:     ex_q.ctrl.mem_wr,
        reg_wr:     ex_q.ctrl.reg_wr,
        link:       ex_q.ctrl.jump,
        rd:         ex_q.rd,
        alu_res:    alu_res,
        store_data: op_b,
        link_addr:  pc_q + 32'd4
    };

endmodule

/* logic/mem_access_stage.sv */
// execute/access register, data memory strobes, result select, write-back register
`timescale 1ns/100ps

module mem_access_stage
    import rv_core_pkg::*;
(
    input  logic    clk_i,
    input  logic    reset_i,
    input  ex_mem_t ex_mem_i,
    input  word_t   data_mem_rdata_i,
    output logic    data_mem_req_o,
    output logic    data_mem_wr_en_o,
    output word_t   data_mem_addr_o,
    output word_t   data_mem_wdata_o,
    output wb_t     mem_fwd_o,
    output wb_t     wb_o
);

    ex_mem_t am_q;
    wb_t     wb_q;
    word_t   result;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            am_q <= '0;
        end else begin
            am_q <= ex_mem_i;
        end
    end

    // --------------------
    // memory strobes
    assign data_mem_req_o   = am_q.mem_rd | am_q.mem_wr;
    assign data_mem_wr_en_o = am_q.mem_wr;
    assign data_mem_addr_o  = am_q.alu_res;
    assign data_mem_wdata_o = am_q.store_data;

    // load data, then link, then alu
    assign result = am_q.mem_rd ? data_mem_rdata_i :
                    am_q.link   ? am_q.link_addr   : am_q.alu_res;

    assign mem_fwd_o = '{we: am_q.reg_wr, rd: am_q.rd, data: result};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_fwd_o;
        end
    end

    assign wb_o = wb_q;

endmodule

/* logic/pipeline_ctrl.sv */
// hazard detection: forward selects, load-use stall and flushes
`timescale 1ns/100ps

module pipeline_ctrl
    import rv_core_pkg::*;
(
    input  reg_addr_t id_rs1_i,
    input  reg_addr_t id_rs2_i,
    input  dec_t      id_ex_ctrl_i,
    input  wb_t       mem_fwd_i,
    input  wb_t       wb_i,
    input  logic      redirect_i,
    output logic      stall_o,
    output logic      flush_id_o,
    output logic      flush_ex_o,
    output fwd_sel_t  fwd_a_o,
    output fwd_sel_t  fwd_b_o
);

    // youngest producer first
    function automatic fwd_sel_t fwd_src(reg_addr_t src, wb_t mem_fwd, wb_t wb);
        if (src == '0) begin
            return FWD_REG;
        end
        if (mem_fwd.we && mem_fwd.rd == src) begin
            return FWD_MEM;
        end
        if (wb.we && wb.rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a_o = fwd_src(id_ex_ctrl_i.rs1, mem_fwd_i, wb_i);
    assign fwd_b_o = fwd_src(id_ex_ctrl_i.rs2, mem_fwd_i, wb_i);

    // load in execute feeding the instruction in decode
    assign stall_o = id_ex_ctrl_i.ctrl.mem_rd && id_ex_ctrl_i.rd != '0 &&
                     (id_ex_ctrl_i.rd == id_rs1_i || id_ex_ctrl_i.rd == id_rs2_i);

    assign flush_id_o = redirect_i;
    assign flush_ex_o = redirect_i | stall_o;

endmodule

/* logic/rv_core.sv */
// five-stage RV32I subset core, stage instances and interconnect
`timescale 1ns/100ps

module rv_core
    import rv_core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk_i,
    input  logic  reset_i,
    input  word_t inst_i,
    output word_t pc_o,
    input  word_t data_mem_rdata_i,
    output logic  data_mem_req_o,
    output logic  data_mem_wr_en_o,
    output word_t data_mem_addr_o,
    output word_t data_mem_wdata_o
);

    word_t    id_pc;
    word_t    id_inst;
    dec_t     id_dec;
    word_t    rs1_data;
    word_t    rs2_data;
    dec_t     id_ex_ctrl;
    logic     redirect;
    word_t    target;
    ex_mem_t  ex_mem;
    wb_t      mem_fwd;
    wb_t      wb;
    logic     stall;
    logic     flush_id;
    logic     flush_ex;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch_stage (
        .clk_i      (clk_i),      .reset_i   (reset_i),
        .stall_i    (stall),      .flush_i   (flush_id),
        .redirect_i (redirect),   .target_i  (target),
        .inst_i     (inst_i),     .pc_o      (pc_o),
        .id_pc_o    (id_pc),      .id_inst_o (id_inst)
    );

    decoder u_decoder (.inst_i(id_inst), .dec_o(id_dec));

    reg_file u_reg_file (
        .clk_i      (clk_i),      .reset_i    (reset_i),
        .rs1_i      (id_dec.rs1), .rs2_i      (id_dec.rs2),
        .rs1_data_o (rs1_data),   .rs2_data_o (rs2_data),
        .wb_i       (wb)
    );

    execute_stage u_execute_stage (
        .clk_i      (clk_i),      .reset_i      (reset_i),
        .flush_i    (flush_ex),   .dec_i        (id_dec),
        .pc_i       (id_pc),      .rs1_data_i   (rs1_data),
        .rs2_data_i (rs2_data),   .fwd_a_i      (fwd_a),
        .fwd_b_i    (fwd_b),      .mem_fwd_i    (mem_fwd),
        .wb_fwd_i   (wb),         .id_ex_ctrl_o (id_ex_ctrl),
        .redirect_o (redirect),   .target_o     (target),
        .ex_mem_o   (ex_mem)
    );

    mem_access_stage u_mem_access_stage (
        .clk_i            (clk_i),            .reset_i          (reset_i),
        .ex_mem_i         (ex_mem),           .data_mem_rdata_i (data_mem_rdata_i),
        .data_mem_req_o   (data_mem_req_o),   .data_mem_wr_en_o (data_mem_wr_en_o),
        .data_mem_addr_o  (data_mem_addr_o),  .data_mem_wdata_o (data_mem_wdata_o),
        .mem_fwd_o        (mem_fwd),          .wb_o             (wb)
    );

    pipeline_ctrl u_pipeline_ctrl (
        .id_rs1_i     (id_dec.rs1), .id_rs2_i   (id_dec.rs2),
        .id_ex_ctrl_i (id_ex_ctrl), .mem_fwd_i  (mem_fwd),
        .wb_i         (wb),         .redirect_i (redirect),
        .stall_o      (stall),      .flush_id_o (flush_id),
        .flush_ex_o   (flush_ex),   .fwd_a_o    (fwd_a),
        .fwd_b_o      (fwd_b)
    );

endmodule

/* tb/rv_core_props.sv */
// concurrent checks on the core's fetch and data memory ports
`timescale 1ns/100ps

module rv_core_props
    import rv_core_pkg::*;
(
    input logic  clk_i,
    input logic  reset_i,
    input word_t pc_i,
    input logic  req_i,
    input logic  wr_en_i
);

    // cycles since reset released, saturating
    logic [1:0] cycles_up;

    // assertion failures so far
    int fail_count = 0;

    always @(posedge clk_i) begin
        if (reset_i) begin
            cycles_up <= '0;
        end else if (cycles_up != 2'd3) begin
            cycles_up <= cycles_up + 2'd1;
        end
    end

    wr_en_with_req: assert property (@(posedge clk_i) wr_en_i |-> req_i)
        else begin
            fail_count++;
            $error("data memory write enable raised without a request");
        end

    pc_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i) pc_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("fetch address is not word aligned");
        end

    strobes_low_in_reset: assert property (
        @(posedge clk_i) reset_i && $past(reset_i) |-> !req_i && !wr_en_i)
        else begin
            fail_count++;
            $error("data memory strobes active during reset");
        end

    no_early_store: assert property (
        @(posedge clk_i) disable iff (reset_i) cycles_up < 2'd3 |-> !wr_en_i)
        else begin
            fail_count++;
            $error("store issued within three cycles of reset release");
        end

endmodule

/* tb/rv_core_checker.sv */
// store monitor comparing data memory writes with the expected store list
`timescale 1ns/100ps

module rv_core_checker
    import rv_core_pkg::*;
#(
    parameter int MAX_STORES = 32
) (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              req_i,
    input  logic                              wr_en_i,
    input  word_t                             addr_i,
    input  word_t                             wdata_i,
    input  logic [MAX_STORES-1:0][2*XLEN-1:0] exp_list_i,
    input  int                                exp_count_i,
    input  logic                              end_i,
    output int                                seen_o,
    output int                                mismatch_o,
    output int                                missing_o,
    output int                                extra_o
);

    int    seen = 0;
    int    mismatches = 0;
    int    missing = 0;
    int    extra = 0;
    word_t exp_addr;
    word_t exp_data;

    // strobes are stable mid-cycle
    always @(negedge clk_i) begin
        if (!reset_i && req_i && wr_en_i) begin
            if (seen >= exp_count_i) begin
                extra++;
                $display("Unexpected store of 0x%08h to address 0x%08h after the last expected one",
                         wdata_i, addr_i);
            end else begin
                {exp_addr, exp_data} = exp_list_i[seen];
                if (addr_i !== exp_addr || wdata_i !== exp_data) begin
                    mismatches++;
                    $display("FAIL %0t: store %0d wrote 0x%08h to 0x%08h, expected 0x%08h to 0x%08h",
                             $time, seen, wdata_i, addr_i, exp_data, exp_addr);
                end
            end
            seen++;
        end
    end

    // anything not seen by the end of the run is missing
    always @(posedge end_i) begin
        if (seen < exp_count_i) begin
            missing = exp_count_i - seen;
            $display("Missing stores: %0d of %0d expected stores never appeared",
                     missing, exp_count_i);
        end
    end

    assign seen_o     = seen;
    assign mismatch_o = mismatches;
    assign missing_o  = missing;
    assign extra_o    = extra;

endmodule

/* tb/rv_core_tb.sv */
// testbench top: clock, reset, program ROM, data memory model, LCG, watchdog, reference model
`timescale 1ns/100ps

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int ROM_WORDS    = 64;
    localparam int DMEM_WORDS   = 64;
    localparam int MAX_STORES   = 32;
    localparam int DRAIN_CYCLES = 20;

    logic  clk;
    logic  reset;
    word_t inst;
    word_t pc;
    word_t rdata;
    logic  mem_req;
    logic  mem_wr_en;
    word_t mem_addr;
    word_t mem_wdata;

    word_t rom [ROM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t dmem_init [DMEM_WORDS];
    logic [MAX_STORES-1:0][2*XLEN-1:0] exp_list;
    int    exp_count;
    int    prog_len;
    word_t lcg_state;
    logic  check_end;
    int    seen;
    int    mismatches;
    int    missing;
    int    extra;
    int    timeouts;

    // --------------------
    // instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic emit_inst(word_t word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    task automatic build_program();
        word_t r_u;
        word_t r_a;
        word_t r_b;
        word_t r_z;
        r_u = lcg_next();
        r_a = lcg_next();
        r_b = lcg_next();
        r_z = lcg_next();
        // unused words are harmless addi x0 carrying their own address
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = enc_i(12'(i * 4), 5'd0, 3'b000, 5'd0, OPC_OPIMM);
        end
        emit_inst(enc_u(r_u[31:12], 5'd1));
        emit_inst(enc_i(r_a[11:0], 5'd1, 3'b000, 5'd1, OPC_OPIMM));
        emit_inst(enc_i(r_b[11:0], 5'd0, 3'b000, 5'd2, OPC_OPIMM));
        emit_inst(enc_i(12'd128, 5'd0, 3'b000, 5'd10, OPC_OPIMM));
        // dependent ALU chain
        emit_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit_inst(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit_inst(enc_r(7'h00, 5'd2, 5'd4, 3'b111, 5'd5));
        emit_inst(enc_r(7'h00, 5'd1, 5'd5, 3'b110, 5'd6));
        emit_inst(enc_r(7'h00, 5'd3, 5'd6, 3'b100, 5'd7));
        emit_inst(enc_r(7'h00, 5'd2, 5'd4, 3'b010, 5'd8));
        emit_inst(enc_s(12'd0, 5'd1, 5'd10));
        emit_inst(enc_s(12'd4, 5'd3, 5'd10));
        emit_inst(enc_s(12'd8, 5'd4, 5'd10));
        emit_inst(enc_s(12'd12, 5'd5, 5'd10));
        emit_inst(enc_s(12'd16, 5'd6, 5'd10));
        emit_inst(enc_s(12'd20, 5'd7, 5'd10));
        emit_inst(enc_s(12'd24, 5'd8, 5'd10));
        // write to x0, then store it
        emit_inst(enc_i(r_z[11:0], 5'd2, 3'b000, 5'd0, OPC_OPIMM));
        emit_inst(enc_s(12'd28, 5'd0, 5'd10));
        // load-use pairs
        emit_inst(enc_i(12'd8, 5'd0, 3'b010, 5'd9, OPC_LOAD));
        emit_inst(enc_r(7'h00, 5'd2, 5'd9, 3'b000, 5'd11));
        emit_inst(enc_s(12'd32, 5'd11, 5'd10));
        emit_inst(enc_i(12'd32, 5'd10, 3'b010, 5'd12, OPC_LOAD));
        emit_inst(enc_s(12'd36, 5'd12, 5'd10));
        // taken branches and a jump, each over dead stores
        emit_inst(enc_b(13'd8, 5'd1, 5'd1, 3'b000));
        emit_inst(enc_s(12'd100, 5'd2, 5'd10));
        emit_inst(enc_b(13'd8, 5'd10, 5'd0, 3'b001));
        emit_inst(enc_s(12'd104, 5'd3, 5'd10));
        emit_inst(enc_b(13'd8, 5'd10, 5'd0, 3'b100));
        emit_inst(enc_s(12'd108, 5'd4, 5'd10));
        emit_inst(enc_j(21'd12, 5'd13));
        emit_inst(enc_s(12'd112, 5'd5, 5'd10));
        emit_inst(enc_s(12'd116, 5'd6, 5'd10));
        emit_inst(enc_s(12'd40, 5'd13, 5'd10));
        // not taken
        emit_inst(enc_b(13'd8, 5'd10, 5'd0, 3'b000));
        emit_inst(enc_s(12'd44, 5'd7, 5'd10));
        emit_inst(enc_j(21'd0, 5'd0));
    endtask

    // --------------------
    // architectural model of the program, one instruction per step
    function automatic void run_reference();
        word_t     regs [32];
        word_t     mem [DMEM_WORDS];
        word_t     pc_r;
        word_t     next_pc;
        word_t     inst_r;
        word_t     a;
        word_t     b;
        word_t     addr;
        word_t     res;
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_j;
        reg_addr_t rd;
        logic      wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = dmem_init[i];
        end
        pc_r      = '0;
        exp_count = 0;
        exp_list  = '0;
        for (int step = 0; step < 40 * ROM_WORDS; step++) begin
            inst_r  = rom[pc_r[7:2]];
            imm_i   = {{20{inst_r[31]}}, inst_r[31:20]};
            imm_s   = {{20{inst_r[31]}}, inst_r[31:25], inst_r[11:7]};
            imm_b   = {{19{inst_r[31]}}, inst_r[31], inst_r[7], inst_r[30:25], inst_r[11:8], 1'b0};
            imm_j   = {{11{inst_r[31]}}, inst_r[31], inst_r[19:12], inst_r[20], inst_r[30:21],
                       1'b0};
            if (inst_r[6:0] == OPC_JAL && imm_j == '0) begin
                break;
            end
            a       = regs[inst_r[19:15]];
            b       = regs[inst_r[24:20]];
            rd      = inst_r[11:7];
            wr      = 1'b1;
            res     = '0;
            next_pc = pc_r + 32'd4;
            case (inst_r[6:0])
                OPC_LUI:   res = {inst_r[31:12], 12'h000};
                OPC_OPIMM: res = a + imm_i;
                OPC_OP: begin
                    case (inst_r[14:12])
                        3'b000:  res = inst_r[30] ? a - b : a + b;
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                OPC_LOAD: begin
                    addr = a + imm_i;
                    res  = mem[addr[7:2]];
                end
                OPC_STORE: begin
                    wr                  = 1'b0;
                    addr                = a + imm_s;
                    mem[addr[7:2]]      = b;
                    exp_list[exp_count] = {addr, b};
                    exp_count++;
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if ((inst_r[14:12] == 3'b000 && a == b) ||
                        (inst_r[14:12] == 3'b001 && a != b) ||
                        (inst_r[14:12] == 3'b100 && $signed(a) < $signed(b))) begin
                        next_pc = pc_r + imm_b;
                    end
                end
                OPC_JAL: begin
                    res     = pc_r + 32'd4;
                    next_pc = pc_r + imm_j;
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != '0) begin
                regs[rd] = res;
            end
            pc_r = next_pc;
        end
    endfunction

    // --------------------
    // closing line, verdict and end of simulation
    task automatic close_run();
        check_end = 1'b1;
        @(posedge clk);
        $display("errors: %0d mismatched, %0d missing, %0d extra, %0d assertion, %0d timeout",
                 mismatches, missing, extra, u_dut.u_props.fail_count, timeouts);
        if (mismatches + missing + extra + u_dut.u_props.fail_count + timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // --------------------
    // clock, memories and DUT
    always #(CLK_PERIOD / 2) clk = ~clk;

    // fetch and load data answer within the cycle, load data only on a request
    always @(negedge clk) begin
        inst  <= rom[pc[7:2]];
        rdata <= mem_req ? dmem[mem_addr[7:2]] : 'x;
    end

    always @(posedge clk) begin
        if (!reset && mem_req && mem_wr_en) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    rv_core #(.RESET_PC(32'h0000_0000)) u_dut (
        .clk_i            (clk),
        .reset_i          (reset),
        .inst_i           (inst),
        .pc_o             (pc),
        .data_mem_rdata_i (rdata),
        .data_mem_req_o   (mem_req),
        .data_mem_wr_en_o (mem_wr_en),
        .data_mem_addr_o  (mem_addr),
        .data_mem_wdata_o (mem_wdata)
    );

    rv_core_checker #(.MAX_STORES(MAX_STORES)) u_checker (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_i       (mem_req),
        .wr_en_i     (mem_wr_en),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .exp_list_i  (exp_list),
        .exp_count_i (exp_count),
        .end_i       (check_end),
        .seen_o      (seen),
        .mismatch_o  (mismatches),
        .missing_o   (missing),
        .extra_o     (extra)
    );

    bind rv_core rv_core_props u_props (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .pc_i    (pc_o),
        .req_i   (data_mem_req_o),
        .wr_en_i (data_mem_wr_en_o)
    );

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        inst      = NOP_INST;
        rdata     = '0;
        check_end = 1'b0;
        timeouts  = 0;
        lcg_state = 32'h51443ce4;
        prog_len  = 0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_init[i] = lcg_next() ^ word_t'(i * 4);
            dmem[i]      = dmem_init[i];
        end
        build_program();
        run_reference();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (seen == exp_count);
        // room for any stray store after the last expected one
        repeat (DRAIN_CYCLES) @(posedge clk);
        close_run();
    end

    // watchdog, 40 cycles per program instruction
    initial begin
        @(negedge reset);
        repeat (40 * prog_len) @(posedge clk);
        $display("Timeout: only %0d of %0d expected stores seen after %0d cycles",
                 seen, exp_count, 40 * prog_len);
        timeouts++;
        close_run();
    end

endmodule

/* rv_core.f */
logic/rv_core_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/mem_access_stage.sv
logic/pipeline_ctrl.sv
logic/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv
